/* logic/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    // Fetch port geometry
    localparam int unsigned FETCH_AW = 32;
    localparam int unsigned FETCH_DW = 32;

    // Line geometry
    localparam int unsigned LINE_WIDTH = 128;
    localparam int unsigned LINE_ALIGN = 4;
    localparam int unsigned FETCH_ALIGN = 2;

    // Everything above the line offset is tag, the cache is fully associative
    localparam int unsigned TAG_WIDTH = FETCH_AW - LINE_ALIGN;

    // Words per line and the width of the word index
    localparam int unsigned WORDS_PER_LINE = LINE_WIDTH / FETCH_DW;
    localparam int unsigned WORD_SEL_WIDTH = LINE_ALIGN - FETCH_ALIGN;

    // Request ID is {port id, prefetch flag}
    localparam int unsigned ID_WIDTH_REQ = 2;

endpackage

`default_nettype wire

/* logic/l0_tag_array.sv */
`timescale 1ns/1ps
`default_nettype none

module l0_tag_array import icache_pkg::*; #(
    parameter int unsigned LINE_COUNT = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic [FETCH_AW-1:0]   fetch_addr_i,
    input  logic [FETCH_AW-1:0]   pf_addr_i,
    input  logic [LINE_COUNT-1:0] evict_strb_i,
    input  logic [FETCH_AW-1:0]   evict_addr_i,
    input  logic [LINE_COUNT-1:0] validate_strb_i,
    output logic [LINE_COUNT-1:0] fetch_hit_o,
    output logic                  pf_present_o
);

    logic [TAG_WIDTH-1:0]  tag_q [LINE_COUNT];
    logic [LINE_COUNT-1:0] valid_q;

    logic [TAG_WIDTH-1:0]  fetch_tag;
    logic [TAG_WIDTH-1:0]  pf_tag;
    logic [TAG_WIDTH-1:0]  evict_tag;
    logic [LINE_COUNT-1:0] pf_match;

    assign fetch_tag = fetch_addr_i[FETCH_AW-1:LINE_ALIGN];
    assign pf_tag    = pf_addr_i[FETCH_AW-1:LINE_ALIGN];
    assign evict_tag = evict_addr_i[FETCH_AW-1:LINE_ALIGN];

    // Valid bits, eviction wins over validate
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < LINE_COUNT; i++) begin
                if (evict_strb_i[i]) begin
                    valid_q[i] <= 1'b0;
                end else if (validate_strb_i[i]) begin
                    valid_q[i] <= 1'b1;
                end
            end
        end
    end

    // Tag is loaded when the line is handed to a new refill
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < LINE_COUNT; i++) begin
            if (evict_strb_i[i]) begin
                tag_q[i] <= evict_tag;
            end
        end
    end

    // Fetch and prefetch compares side by side
    always_comb begin
        for (int i = 0; i < LINE_COUNT; i++) begin
            fetch_hit_o[i] = valid_q[i] && (tag_q[i] == fetch_tag);
            pf_match[i]    = valid_q[i] && (tag_q[i] == pf_tag);
        end
    end

    assign pf_present_o = |pf_match;

endmodule

`default_nettype wire

/* logic/l0_data_array.sv */
`timescale 1ns/1ps
`default_nettype none

module l0_data_array import icache_pkg::*; #(
    parameter int unsigned LINE_COUNT = 4
) (
    input  logic                  clk_i,
    input  logic [LINE_COUNT-1:0] validate_strb_i,
    input  logic [LINE_WIDTH-1:0] line_i,
    input  logic [LINE_COUNT-1:0] fetch_hit_i,
    input  logic [FETCH_AW-1:0]   fetch_addr_i,
    output logic [FETCH_DW-1:0]   data_o
);

    logic [LINE_WIDTH-1:0] line_q [LINE_COUNT];
    logic [LINE_WIDTH-1:0] hit_line;

    // Same bits as hit_line, viewed as words
    logic [WORDS_PER_LINE-1:0][FETCH_DW-1:0] hit_words;
    logic [WORD_SEL_WIDTH-1:0]               word_sel;

    // Line storage, written straight from the response bus
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < LINE_COUNT; i++) begin
            if (validate_strb_i[i]) begin
                line_q[i] <= line_i;
            end
        end
    end

    // Hit vector is one-hot, so an OR tree is enough
    always_comb begin
        hit_line = '0;
        for (int i = 0; i < LINE_COUNT; i++) begin
            hit_line = hit_line | (fetch_hit_i[i] ? line_q[i] : '0);
        end
    end

    assign hit_words = hit_line;
    assign word_sel  = fetch_addr_i[LINE_ALIGN-1:FETCH_ALIGN];

    // Word within the line
    assign data_o = hit_words[word_sel];

endmodule

`default_nettype wire

/* logic/l0_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module l0_ctrl #(
    parameter int unsigned LINE_COUNT = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  in_valid_i,
    input  logic [LINE_COUNT-1:0] fetch_hit_i,
    input  logic                  req_valid_i,
    input  logic                  req_ready_i,
    input  logic                  grant_is_prefetch_i,
    input  logic                  rsp_valid_i,
    input  logic                  rsp_error_i,
    output logic                  in_ready_o,
    output logic                  in_error_o,
    output logic                  rsp_ready_o,
    output logic                  demand_valid_o,
    output logic                  req_enable_o,
    output logic [LINE_COUNT-1:0] evict_strb_o,
    output logic [LINE_COUNT-1:0] validate_strb_o,
    output logic                  refill_done_o
);

    localparam int unsigned VICTIM_W = (LINE_COUNT > 1) ? $clog2(LINE_COUNT) : 1;

    logic hit_any;
    logic miss;
    logic grant;
    logic rsp_fire;

    // Outstanding refill
    logic                  pending_q;
    logic                  pend_pf_q;
    logic [LINE_COUNT-1:0] pend_line_q;

    logic [VICTIM_W-1:0] victim_q;
    logic                err_q;
    logic                done_q;

    assign hit_any  = |fetch_hit_i;
    assign miss     = in_valid_i & ~hit_any;
    assign grant    = req_valid_i & req_ready_i;
    assign rsp_fire = rsp_valid_i & rsp_ready_o & pending_q;

    // Responses are always taken in their own cycle
    assign rsp_ready_o = 1'b1;

    // No new request in the cycle an errored fetch completes
    assign demand_valid_o = miss & ~err_q;
    assign req_enable_o   = ~pending_q;

    assign in_ready_o    = hit_any | err_q;
    assign in_error_o    = err_q;
    assign refill_done_o = done_q;

    // Victim is only claimed once the request is accepted
    always_comb begin
        evict_strb_o = '0;
        if (grant) begin
            evict_strb_o[victim_q] = 1'b1;
        end
    end

    // A failed refill leaves its line invalid
    assign validate_strb_o = (rsp_fire && !rsp_error_i) ? pend_line_q : '0;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q   <= 1'b0;
            pend_pf_q   <= 1'b0;
            pend_line_q <= '0;
            victim_q    <= '0;
            err_q       <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            err_q  <= rsp_fire & ~pend_pf_q & rsp_error_i;
            done_q <= rsp_fire & ~pend_pf_q & ~rsp_error_i;
            if (grant) begin
                pending_q   <= 1'b1;
                pend_pf_q   <= grant_is_prefetch_i;
                pend_line_q <= evict_strb_o;
                if (victim_q == VICTIM_W'(LINE_COUNT - 1)) begin
                    victim_q <= '0;
                end else begin
                    victim_q <= victim_q + 1'b1;
                end
            end else if (rsp_fire) begin
                pending_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/next_line_prefetcher.sv */
`timescale 1ns/1ps
`default_nettype none

module next_line_prefetcher import icache_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                refill_done_i,
    input  logic [FETCH_AW-1:0] fetch_addr_i,
    input  logic                pf_present_i,
    input  logic                pf_taken_i,
    output logic [FETCH_AW-1:0] pf_addr_o,
    output logic                pf_valid_o
);

    logic [TAG_WIDTH-1:0] next_tag;
    logic [FETCH_AW-1:0]  cand_addr;
    logic                 load;

    // Single entry queue
    logic                queue_valid_q;
    logic [FETCH_AW-1:0] queue_addr_q;

    // Line following the one being fetched
    assign next_tag  = fetch_addr_i[FETCH_AW-1:LINE_ALIGN] + 1'b1;
    assign cand_addr = {next_tag, {LINE_ALIGN{1'b0}}};

    // pf_present_i refers to the candidate whenever the queue is empty
    assign load = refill_done_i & ~pf_present_i & ~queue_valid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            queue_valid_q <= 1'b0;
        end else if (load) begin
            queue_valid_q <= 1'b1;
        end else if (pf_taken_i) begin
            queue_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            queue_addr_q <= cand_addr;
        end
    end

    // Queued address is held steady for the request channel
    assign pf_addr_o  = queue_valid_q ? queue_addr_q : cand_addr;
    assign pf_valid_o = queue_valid_q;

endmodule

`default_nettype wire

/* logic/refill_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module refill_arbiter import icache_pkg::*; #(
    parameter int unsigned PORT_ID = 0
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    demand_valid_i,
    input  logic [FETCH_AW-1:0]     demand_addr_i,
    input  logic                    pf_valid_i,
    input  logic [FETCH_AW-1:0]     pf_addr_i,
    input  logic                    enable_i,
    input  logic                    req_ready_i,
    output logic [FETCH_AW-1:0]     req_addr_o,
    output logic [ID_WIDTH_REQ-1:0] req_id_o,
    output logic                    req_valid_o,
    output logic                    pf_taken_o,
    output logic                    grant_is_prefetch_o
);

    localparam logic [ID_WIDTH_REQ-2:0] PORT_BITS = (ID_WIDTH_REQ - 1)'(PORT_ID);

    logic dem_req;
    logic pf_req;
    logic sel_pf;
    logic grant;

    // prio_q set means the prefetch source goes first
    logic prio_q;
    logic lock_q;
    logic lock_sel_q;

    assign dem_req = enable_i & demand_valid_i;
    assign pf_req  = enable_i & pf_valid_i;

    // Keep the previous pick while the channel stalls
    always_comb begin
        if (lock_q) begin
            sel_pf = lock_sel_q;
        end else if (dem_req && pf_req) begin
            sel_pf = prio_q;
        end else begin
            sel_pf = pf_req & ~dem_req;
        end
    end

    assign req_valid_o = sel_pf ? pf_req : dem_req;
    assign grant       = req_valid_o & req_ready_i;

    assign pf_taken_o          = grant & sel_pf;
    assign grant_is_prefetch_o = sel_pf;

    assign req_addr_o = sel_pf ? pf_addr_i
                               : {demand_addr_i[FETCH_AW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};
    assign req_id_o   = {PORT_BITS, sel_pf};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prio_q     <= 1'b0;
            lock_q     <= 1'b0;
            lock_sel_q <= 1'b0;
        end else begin
            lock_q     <= req_valid_o & ~req_ready_i;
            lock_sel_q <= sel_pf;
            // The loser of this grant goes first next time
            if (grant) begin
                prio_q <= ~sel_pf;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/icache_l0_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_l0_top import icache_pkg::*; #(
    parameter int unsigned LINE_COUNT = 4,
    parameter int unsigned PORT_ID    = 0
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,

    // Core fetch port
    input  logic [FETCH_AW-1:0]     in_addr_i,
    input  logic                    in_valid_i,
    output logic [FETCH_DW-1:0]     in_data_o,
    output logic                    in_ready_o,
    output logic                    in_error_o,

    // Refill requests to the next level
    output logic [FETCH_AW-1:0]     out_req_addr_o,
    output logic [ID_WIDTH_REQ-1:0] out_req_id_o,
    output logic                    out_req_valid_o,
    input  logic                    out_req_ready_i,

    // Refill responses
    input  logic [LINE_WIDTH-1:0]   out_rsp_data_i,
    input  logic                    out_rsp_error_i,
    input  logic                    out_rsp_valid_i,
    output logic                    out_rsp_ready_o
);

    logic [LINE_COUNT-1:0] fetch_hit;
    logic [LINE_COUNT-1:0] evict_strb;
    logic [LINE_COUNT-1:0] validate_strb;
    logic                  pf_present;
    logic                  demand_valid;
    logic                  req_enable;
    logic                  refill_done;
    logic                  pf_valid;
    logic [FETCH_AW-1:0]   pf_addr;
    logic                  pf_taken;
    logic                  grant_is_prefetch;

    l0_ctrl #(
        .LINE_COUNT (LINE_COUNT)
    ) u_ctrl (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .in_valid_i          (in_valid_i),
        .fetch_hit_i         (fetch_hit),
        .req_valid_i         (out_req_valid_o),
        .req_ready_i         (out_req_ready_i),
        .grant_is_prefetch_i (grant_is_prefetch),
        .rsp_valid_i         (out_rsp_valid_i),
        .rsp_error_i         (out_rsp_error_i),
        .in_ready_o          (in_ready_o),
        .in_error_o          (in_error_o),
        .rsp_ready_o         (out_rsp_ready_o),
        .demand_valid_o      (demand_valid),
        .req_enable_o        (req_enable),
        .evict_strb_o        (evict_strb),
        .validate_strb_o     (validate_strb),
        .refill_done_o       (refill_done)
    );

    // Eviction loads the tag of whatever request was granted
    l0_tag_array #(
        .LINE_COUNT (LINE_COUNT)
    ) u_tags (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .fetch_addr_i    (in_addr_i),
        .pf_addr_i       (pf_addr),
        .evict_strb_i    (evict_strb),
        .evict_addr_i    (out_req_addr_o),
        .validate_strb_i (validate_strb),
        .fetch_hit_o     (fetch_hit),
        .pf_present_o    (pf_present)
    );

    l0_data_array #(
        .LINE_COUNT (LINE_COUNT)
    ) u_data (
        .clk_i           (clk_i),
        .validate_strb_i (validate_strb),
        .line_i          (out_rsp_data_i),
        .fetch_hit_i     (fetch_hit),
        .fetch_addr_i    (in_addr_i),
        .data_o          (in_data_o)
    );

    next_line_prefetcher u_prefetch (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .refill_done_i (refill_done),
        .fetch_addr_i  (in_addr_i),
        .pf_present_i  (pf_present),
        .pf_taken_i    (pf_taken),
        .pf_addr_o     (pf_addr),
        .pf_valid_o    (pf_valid)
    );

    refill_arbiter #(
        .PORT_ID (PORT_ID)
    ) u_arb (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .demand_valid_i      (demand_valid),
        .demand_addr_i       (in_addr_i),
        .pf_valid_i          (pf_valid),
        .pf_addr_i           (pf_addr),
        .enable_i            (req_enable),
        .req_ready_i         (out_req_ready_i),
        .req_addr_o          (out_req_addr_o),
        .req_id_o            (out_req_id_o),
        .req_valid_o         (out_req_valid_o),
        .pf_taken_o          (pf_taken),
        .grant_is_prefetch_o (grant_is_prefetch)
    );

endmodule

`default_nettype wire

/* testbench/icache_l0_props.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_l0_props #(
    parameter int unsigned LINE_COUNT = 4
) (
    input logic                  clk_i,
    input logic                  rst_ni,
    input logic                  req_valid_i,
    input logic                  req_ready_i,
    input logic                  req_is_prefetch_i,
    input logic                  pending_i,
    input logic [LINE_COUNT-1:0] fetch_hit_i,
    input logic                  refill_done_i,
    input logic                  in_ready_i,
    input logic                  in_error_i
);

    // A stalled request keeps its valid and its source
    req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_is_prefetch_i))
        else $error("request dropped or changed source while stalled");

    // Nothing new goes out while a refill is in flight
    single_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pending_i |-> !req_valid_i)
        else $error("second request raised with a refill outstanding");

    // The waiting fetch hits right after its good refill
    refill_hits: assert property (@(posedge clk_i) disable iff (!rst_ni)
        refill_done_i |-> (|fetch_hit_i))
        else $error("fetch did not hit after its refill completed");

    // Errored refill completes the fetch while its line stays invalid
    error_completes: assert property (@(posedge clk_i) disable iff (!rst_ni)
        in_error_i |-> in_ready_i && !(|fetch_hit_i))
        else $error("fetch error flagged with a hit or without fetch completion");

endmodule

bind l0_ctrl icache_l0_props #(
    .LINE_COUNT (LINE_COUNT)
) u_props (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_valid_i       (req_valid_i),
    .req_ready_i       (req_ready_i),
    .req_is_prefetch_i (grant_is_prefetch_i),
    .pending_i         (pending_q),
    .fetch_hit_i       (fetch_hit_i),
    .refill_done_i     (refill_done_o),
    .in_ready_i        (in_ready_o),
    .in_error_i        (in_error_o)
);

`default_nettype wire

/* testbench/tb_icache_l0.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_icache_l0 import icache_pkg::*; ();

    localparam int unsigned LINE_COUNT = 4;
    localparam int unsigned PORT_ID    = 0;
    localparam int          TIMEOUT    = 100;
    localparam logic [FETCH_DW-1:0] WORD_MASK = 32'hC0DE_0000;

    logic                    clk_i;
    logic                    rst_ni;
    logic [FETCH_AW-1:0]     in_addr_i;
    logic                    in_valid_i;
    logic [FETCH_DW-1:0]     in_data_o;
    logic                    in_ready_o;
    logic                    in_error_o;
    logic [FETCH_AW-1:0]     out_req_addr_o;
    logic [ID_WIDTH_REQ-1:0] out_req_id_o;
    logic                    out_req_valid_o;
    logic                    out_req_ready_i = 1'b0;
    logic [LINE_WIDTH-1:0]   out_rsp_data_i  = '0;
    logic                    out_rsp_error_i = 1'b0;
    logic                    out_rsp_valid_i = 1'b0;
    logic                    out_rsp_ready_o;

    // Next level model state
    integer              seed        = 81715;
    int                  accept_wait = 0;
    int                  rsp_wait    = 0;
    int                  rsp_total   = 0;
    logic [FETCH_AW-1:0] rsp_addr    = '0;
    logic                stall       = 1'b0;
    logic                err_en      = 1'b0;
    logic [FETCH_AW-1:0] err_addr    = '0;

    // Every granted request in order
    logic [FETCH_AW-1:0]     log_addr [$];
    logic [ID_WIDTH_REQ-1:0] log_id [$];

    int checks = 0;
    int errors = 0;

    icache_l0_top #(
        .LINE_COUNT (LINE_COUNT),
        .PORT_ID    (PORT_ID)
    ) uut (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .in_addr_i       (in_addr_i),
        .in_valid_i      (in_valid_i),
        .in_data_o       (in_data_o),
        .in_ready_o      (in_ready_o),
        .in_error_o      (in_error_o),
        .out_req_addr_o  (out_req_addr_o),
        .out_req_id_o    (out_req_id_o),
        .out_req_valid_o (out_req_valid_o),
        .out_req_ready_i (out_req_ready_i),
        .out_rsp_data_i  (out_rsp_data_i),
        .out_rsp_error_i (out_rsp_error_i),
        .out_rsp_valid_i (out_rsp_valid_i),
        .out_rsp_ready_o (out_rsp_ready_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [FETCH_DW-1:0] expected_word(input logic [FETCH_AW-1:0] addr);
        return addr ^ WORD_MASK;
    endfunction

    function automatic logic [LINE_WIDTH-1:0] line_image(input logic [FETCH_AW-1:0] addr);
        logic [FETCH_AW-1:0]   base;
        logic [LINE_WIDTH-1:0] line;
        base = {addr[FETCH_AW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};
        line = '0;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[w*FETCH_DW +: FETCH_DW] = expected_word(base + FETCH_AW'(w * 4));
        end
        return line;
    endfunction

    // Count demand requests logged from index from onward
    function automatic int demand_count(input int from, input logic [FETCH_AW-1:0] addr,
                                        input bit any_addr);
        int n;
        n = 0;
        for (int i = from; i < log_addr.size(); i++) begin
            if (!log_id[i][0] && (any_addr || log_addr[i] == addr)) begin
                n++;
            end
        end
        return n;
    endfunction

    // Accept after a random delay and answer two cycles later
    always @(posedge clk_i) begin
        if (out_rsp_valid_i) begin
            check_value("out_rsp_ready_o", 32'(out_rsp_ready_o), 1);
        end
        out_rsp_valid_i <= 1'b0;
        out_rsp_error_i <= 1'b0;
        if (!rst_ni) begin
            out_req_ready_i <= 1'b0;
            rsp_wait = 0;
        end else if (out_req_valid_o && out_req_ready_i) begin
            out_req_ready_i <= 1'b0;
            log_addr.push_back(out_req_addr_o);
            log_id.push_back(out_req_id_o);
            rsp_addr    = out_req_addr_o;
            rsp_wait    = 2;
            accept_wait = {$random(seed)} % 4;
        end else if (rsp_wait != 0) begin
            rsp_wait = rsp_wait - 1;
            if (rsp_wait == 0) begin
                out_rsp_valid_i <= 1'b1;
                out_rsp_data_i  <= line_image(rsp_addr);
                out_rsp_error_i <= err_en &&
                    (rsp_addr[FETCH_AW-1:LINE_ALIGN] == err_addr[FETCH_AW-1:LINE_ALIGN]);
                rsp_total++;
            end
        end else if (out_req_valid_o && !stall) begin
            if (accept_wait == 0) begin
                out_req_ready_i <= 1'b1;
            end else begin
                accept_wait = accept_wait - 1;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Settled once nothing is requested and every request has been answered
    task automatic wait_idle();
        int n;
        bit idle;
        n    = 0;
        idle = 1'b0;
        while (!idle && n < TIMEOUT) begin
            @(negedge clk_i);
            idle = !out_req_valid_o && !out_rsp_valid_i && (rsp_total == log_addr.size());
            n++;
        end
        if (!idle) begin
            errors++;
            $display("Timeout: refill traffic did not settle");
        end
    endtask

    task automatic expect_request(input logic [FETCH_AW-1:0] addr, input int exp_id);
        int n;
        int idx;
        n   = 0;
        idx = -1;
        while (idx < 0 && n < TIMEOUT) begin
            @(negedge clk_i);
            for (int i = 0; i < log_addr.size(); i++) begin
                if (idx < 0 && log_addr[i] == addr) begin
                    idx = i;
                end
            end
            n++;
        end
        if (idx < 0) begin
            errors++;
            $display("Timeout: no request was seen for address %h", addr);
        end else begin
            check_value("out_req_id_o", 32'(log_id[idx]), exp_id);
        end
    endtask

    task automatic start_fetch(input logic [FETCH_AW-1:0] addr);
        @(posedge clk_i);
        in_addr_i  <= addr;
        in_valid_i <= 1'b1;
    endtask

    // Cycles counts only the extra wait so a hit gives zero
    task automatic wait_fetch(input logic [FETCH_AW-1:0] addr, output logic [FETCH_DW-1:0] data,
                              output logic err, output int cycles);
        bit done;
        done   = 1'b0;
        cycles = 0;
        data   = '0;
        err    = 1'b0;
        while (!done && cycles < TIMEOUT) begin
            @(negedge clk_i);
            if (in_ready_o) begin
                data = in_data_o;
                err  = in_error_o;
                done = 1'b1;
            end else begin
                cycles++;
            end
        end
        if (!done) begin
            errors++;
            $display("Timeout: fetch of %h never completed", addr);
        end
        @(posedge clk_i);
        in_valid_i <= 1'b0;
    endtask

    task automatic fetch_check(input logic [FETCH_AW-1:0] addr, input logic exp_err,
                               output int cycles);
        logic [FETCH_DW-1:0] data;
        logic                err;
        start_fetch(addr);
        wait_fetch(addr, data, err, cycles);
        check_value("in_error_o", 32'(err), 32'(exp_err));
        if (!exp_err) begin
            check_value("in_data_o", data, expected_word(addr));
        end
    endtask

    task automatic cold_miss_test();
        int from;
        int cycles;
        from = log_addr.size();
        fetch_check(32'h100, 1'b0, cycles);
        check_value("demand requests", demand_count(from, '0, 1'b1), 1);
        check_value("demand requests at 100", demand_count(from, 32'h100, 1'b0), 1);
        check_value("out_req_id_o", 32'(log_id[from]), PORT_ID * 2);
    endtask

    task automatic hits_test();
        int from;
        int cycles;
        from = log_addr.size();
        for (int a = 'h104; a <= 'h10C; a += 4) begin
            fetch_check(FETCH_AW'(a), 1'b0, cycles);
            check_value("hit latency", cycles, 0);
        end
        check_value("demand requests on hits", demand_count(from, '0, 1'b1), 0);
    endtask

    task automatic prefetch_test();
        int from;
        int cycles;
        expect_request(32'h110, PORT_ID * 2 + 1);
        wait_idle();
        from = log_addr.size();
        fetch_check(32'h110, 1'b0, cycles);
        check_value("hit latency", cycles, 0);
        check_value("demand requests after prefetch", demand_count(from, '0, 1'b1), 0);
    endtask

    task automatic eviction_test();
        int from;
        int cycles;
        for (int i = 1; i <= LINE_COUNT; i++) begin
            fetch_check(FETCH_AW'(i * 32'h1000), 1'b0, cycles);
            wait_idle();
        end
        from = log_addr.size();
        fetch_check(32'h100, 1'b0, cycles);
        check_value("miss on evicted line", 32'(cycles > 0), 1);
        check_value("demand requests at 100", demand_count(from, 32'h100, 1'b0), 1);
        wait_idle();
    endtask

    task automatic error_test();
        int from;
        int cycles;
        @(posedge clk_i);
        err_addr <= 32'h400;
        err_en   <= 1'b1;
        fetch_check(32'h400, 1'b1, cycles);
        wait_idle();
        @(posedge clk_i);
        err_en <= 1'b0;
        from = log_addr.size();
        fetch_check(32'h400, 1'b0, cycles);
        check_value("demand requests at 400", demand_count(from, 32'h400, 1'b0), 1);
        wait_idle();
    endtask

    task automatic back_pressure_test();
        logic [FETCH_DW-1:0] data;
        logic                err;
        int                  cycles;
        @(posedge clk_i);
        stall <= 1'b1;
        start_fetch(32'h5008);
        repeat (6) begin
            @(negedge clk_i);
            check_value("out_req_valid_o", 32'(out_req_valid_o), 1);
            check_value("out_req_addr_o", out_req_addr_o, 32'h5000);
            check_value("out_req_id_o", 32'(out_req_id_o), PORT_ID * 2);
        end
        @(posedge clk_i);
        stall <= 1'b0;
        wait_fetch(32'h5008, data, err, cycles);
        check_value("in_error_o", 32'(err), 0);
        check_value("in_data_o", data, expected_word(32'h5008));
    endtask

    initial begin
        in_addr_i  = '0;
        in_valid_i = 1'b0;
        rst_ni     = 1'b0;
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_value("out_req_valid_o", 32'(out_req_valid_o), 0);
        check_value("in_ready_o", 32'(in_ready_o), 0);
        check_value("in_error_o", 32'(in_error_o), 0);

        cold_miss_test();
        hits_test();
        prefetch_test();
        eviction_test();
        error_test();
        back_pressure_test();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* icache_l0.f */
logic/icache_pkg.sv
logic/l0_tag_array.sv
logic/l0_data_array.sv
logic/l0_ctrl.sv
logic/next_line_prefetcher.sv
logic/refill_arbiter.sv
logic/icache_l0_top.sv
testbench/icache_l0_props.sv
testbench/tb_icache_l0.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the L0 cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_icache_l0 -f icache_l0.f

out=$(./obj_dir/Vtb_icache_l0)
echo "$out"

if echo "$out" | grep -qx "No errors"; then
    exit 0
else
    exit 1
fi
